// File: compile.f
+incdir+include
rtl/csr_pkg.sv
rtl/csr_decode.sv
rtl/csr_file.sv
rtl/csr_execute.sv
rtl/csr_result.sv
rtl/csr_unit.sv
verification/csr_unit_tb.sv

// File: include/csr_unit_cfg.svh
`ifndef CSR_UNIT_CFG_SVH
`define CSR_UNIT_CFG_SVH

// Core geometry.
`define NUM_THREADS 4
`define NUM_WARPS 4
`define CORE_ID 1

`define CSR_NUM_SCRATCH 16 // Writable CSRs from address 0.

// Per-thread identity CSRs.
`define CSR_THREAD_ID 12'h020
`define CSR_WARP_ID 12'h021
`define CSR_GWARP_ID 12'h022
`define CSR_INSTRET 12'hC02 // Retired instruction counter.

// Update ops, numbered like funct3[1:0].
`define CSR_OP_RW 2'd1
`define CSR_OP_RS 2'd2
`define CSR_OP_RC 2'd3

`endif

// File: rtl/csr_decode.sv
`timescale 1ns/1ps
`include "csr_unit_cfg.svh"

module csr_decode (
	input  csr_pkg::csr_req_t req,
	output csr_pkg::csr_cmd_t cmd
);

	import csr_pkg::*;

	csr_op_t op;
	word_t   mask;
	logic    known_op;
	logic    writable;
	logic    mask_zero;

	// funct3[2] picks the immediate form.
	assign mask = req.funct3[2] ? word_t'(req.zimm) : req.rs1_data;
	assign mask_zero = (mask == '0);

	always_comb begin
		known_op = 1'b1;
		case (req.funct3[1:0])
			2'd1: op = `CSR_OP_RW;
			2'd2: op = `CSR_OP_RS;
			2'd3: op = `CSR_OP_RC;
			default: begin
				op = `CSR_OP_RW;
				known_op = 1'b0; // funct3 0 and 4.
			end
		endcase
	end

	// Only the scratch range takes writes.
	assign writable = (req.csr_addr < `CSR_NUM_SCRATCH);

	always_comb begin
		cmd.valid    = req.valid;
		cmd.warp_num = req.warp_num;
		cmd.rd       = req.rd;
		cmd.wb       = req.wb;
		cmd.csr_addr = req.csr_addr;
		cmd.op       = op;
		cmd.mask     = mask;
		cmd.write_en = known_op && writable;
		if (op != `CSR_OP_RW && mask_zero) begin
			cmd.write_en = 1'b0; // Set or clear with nothing to change.
		end
	end

endmodule

// File: rtl/csr_execute.sv
`timescale 1ns/1ps
`include "csr_unit_cfg.svh"

module csr_execute (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               no_slot_csr,
	input  csr_pkg::csr_cmd_t  cmd,
	output csr_pkg::csr_addr_t rd_addr,
	input  csr_pkg::word_t     rd_data,
	output logic               wr_en,
	output csr_pkg::csr_addr_t wr_addr,
	output csr_pkg::word_t     wr_data,
	output csr_pkg::csr_s2_t   s2,
	output logic               stall_gpr_csr
);

	import csr_pkg::*;

	logic    req_present;
	logic    s2_write;
	logic    fwd_hit;
	word_t   cur_word;
	word_t   upd_word;
	csr_s2_t s2_next;

	assign req_present   = |cmd.valid;
	assign stall_gpr_csr = req_present && no_slot_csr;
	assign rd_addr       = cmd.csr_addr;

	// Stage 2 write not yet in the file.
	assign s2_write = (|s2.valid) && s2.write_en;
	assign fwd_hit  = s2_write && (s2.csr_addr == cmd.csr_addr);
	assign cur_word = fwd_hit ? s2.new_word : rd_data;

	always_comb begin
		case (cmd.op)
			`CSR_OP_RS: upd_word = cur_word | cmd.mask;
			`CSR_OP_RC: upd_word = cur_word & ~cmd.mask;
			default:    upd_word = cmd.mask;
		endcase
	end

	always_comb begin
		s2_next.valid    = cmd.valid; // Zero when idle.
		s2_next.warp_num = cmd.warp_num;
		s2_next.rd       = cmd.rd;
		s2_next.wb       = cmd.wb;
		s2_next.csr_addr = cmd.csr_addr;
		s2_next.write_en = cmd.write_en;
		s2_next.rd_word  = cur_word;
		s2_next.new_word = upd_word;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s2 <= '0;
		end else if (!no_slot_csr) begin
			s2 <= s2_next; // Held while writeback has no slot.
		end
	end

	// Commit as the entry leaves stage 2.
	assign wr_en   = s2_write && !no_slot_csr;
	assign wr_addr = s2.csr_addr;
	assign wr_data = s2.new_word;

endmodule

// File: rtl/csr_file.sv
`timescale 1ns/1ps
`include "csr_unit_cfg.svh"

module csr_file (
	input  logic               clk,
	input  logic               rst_n,
	input  csr_pkg::csr_addr_t rd_addr,
	output csr_pkg::word_t     rd_data,
	input  logic               wr_en,
	input  csr_pkg::csr_addr_t wr_addr,
	input  csr_pkg::word_t     wr_data,
	input  logic               wb_valid
);

	import csr_pkg::*;

	localparam int IDX_W = $clog2(`CSR_NUM_SCRATCH);

	word_t            scratch [`CSR_NUM_SCRATCH];
	word_t            instret;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;

	assign wr_idx = wr_addr[IDX_W-1:0];
	assign rd_idx = rd_addr[IDX_W-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CSR_NUM_SCRATCH; i++) begin
				scratch[i] <= '0;
			end
		end else if (wr_en) begin
			scratch[wr_idx] <= wr_data; // Address already checked by decode.
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instret <= '0;
		end else if (wb_valid) begin
			instret <= instret + 1'b1;
		end
	end

	// Read port, zero outside the implemented CSRs.
	always_comb begin
		if (rd_addr < `CSR_NUM_SCRATCH) begin
			rd_data = scratch[rd_idx];
		end else if (rd_addr == `CSR_INSTRET) begin
			rd_data = instret;
		end else begin
			rd_data = '0;
		end
	end

endmodule

// File: rtl/csr_pkg.sv
`include "csr_unit_cfg.svh"

package csr_pkg;

	typedef logic [31:0] word_t;
	typedef logic [11:0] csr_addr_t;
	typedef logic [$clog2(`NUM_WARPS)-1:0] warp_num_t;
	typedef logic [`NUM_THREADS-1:0] thread_mask_t;
	typedef logic [4:0] reg_num_t;
	typedef logic [1:0] csr_op_t;

	typedef struct packed {
		thread_mask_t valid; // Zero means no request.
		warp_num_t    warp_num;
		reg_num_t     rd;
		logic         wb;
		logic [2:0]   funct3;
		csr_addr_t    csr_addr;
		word_t        rs1_data;
		logic [4:0]   zimm;
	} csr_req_t;

	typedef struct packed {
		thread_mask_t valid;
		warp_num_t    warp_num;
		reg_num_t     rd;
		logic         wb;
		csr_addr_t    csr_addr;
		csr_op_t      op;
		word_t        mask;
		logic         write_en;
	} csr_cmd_t;

	// Stage 2 carries the read word and the new word instead of the op.
	typedef struct packed {
		thread_mask_t valid;
		warp_num_t    warp_num;
		reg_num_t     rd;
		logic         wb;
		csr_addr_t    csr_addr;
		logic         write_en;
		word_t        rd_word;
		word_t        new_word;
	} csr_s2_t;

	typedef struct packed {
		thread_mask_t                 valid;
		warp_num_t                    warp_num;
		reg_num_t                     rd;
		logic                         wb;
		word_t [`NUM_THREADS-1:0]     result; // One word per thread.
	} csr_wb_t;

endpackage

// File: rtl/csr_result.sv
`timescale 1ns/1ps
`include "csr_unit_cfg.svh"

module csr_result (
	input  csr_pkg::csr_s2_t s2,
	output csr_pkg::csr_wb_t csr_wb
);

	import csr_pkg::*;

	word_t warp_word;
	word_t gwarp_word;

	assign warp_word  = word_t'(s2.warp_num);
	assign gwarp_word = warp_word + word_t'(`CORE_ID * `NUM_WARPS); // Global warp ID.

	always_comb begin
		csr_wb.valid    = s2.valid;
		csr_wb.warp_num = s2.warp_num;
		csr_wb.rd       = s2.rd;
		csr_wb.wb       = s2.wb;
		for (int t = 0; t < `NUM_THREADS; t++) begin
			case (s2.csr_addr)
				`CSR_THREAD_ID: csr_wb.result[t] = word_t'(t);
				`CSR_WARP_ID:   csr_wb.result[t] = warp_word;
				`CSR_GWARP_ID:  csr_wb.result[t] = gwarp_word;
				default:        csr_wb.result[t] = s2.rd_word; // Same word to all threads.
			endcase
		end
	end

endmodule

// File: rtl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  csr_pkg::csr_req_t req,
	input  logic              no_slot_csr,
	input  logic              wb_valid,
	output csr_pkg::csr_wb_t  csr_wb,
	output logic              stall_gpr_csr
);

	import csr_pkg::*;

	csr_cmd_t  cmd;
	csr_addr_t rd_addr;
	word_t     rd_data;
	logic      wr_en;
	csr_addr_t wr_addr;
	word_t     wr_data;
	csr_s2_t   s2;

	csr_decode i_decode (
		.req (req),
		.cmd (cmd)
	);

	csr_file i_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.wb_valid (wb_valid)
	);

	csr_execute i_execute (
		.clk           (clk),
		.rst_n         (rst_n),
		.no_slot_csr   (no_slot_csr),
		.cmd           (cmd),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.s2            (s2),
		.stall_gpr_csr (stall_gpr_csr)
	);

	csr_result i_result (
		.s2     (s2),
		.csr_wb (csr_wb)
	);

endmodule

// File: verification/csr_unit_tb.sv
`timescale 1ns/1ps
`include "csr_unit_cfg.svh"

module csr_unit_tb;

	import csr_pkg::*;

	localparam int CLK_PERIOD     = 10;
	localparam int RESET_CYCLES   = 8;
	localparam int NUM_REQS       = 2000;
	localparam int CYCLES_PER_REQ = 20;
	localparam int TIMEOUT_NS     = (RESET_CYCLES + NUM_REQS * CYCLES_PER_REQ) * CLK_PERIOD;

	logic     clk;
	logic     rst_n;
	csr_req_t req;
	logic     no_slot_csr;
	logic     wb_valid;
	csr_wb_t  csr_wb;
	logic     stall_gpr_csr;

	word_t       csr_model [`CSR_NUM_SCRATCH];
	word_t       instret_count;
	csr_wb_t     exp_wb; // What csr_wb should show now.
	int          accepted_count;
	csr_addr_t   prev_addr;
	int unsigned seed_dummy;

	csr_unit i_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req),
		.no_slot_csr   (no_slot_csr),
		.wb_valid      (wb_valid),
		.csr_wb        (csr_wb),
		.stall_gpr_csr (stall_gpr_csr)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERR %0t ns %s got %h expected %h", $time, name, got, expected);
			$display("TESTBENCH FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	function automatic word_t model_read(input csr_addr_t addr);
		if (addr < `CSR_NUM_SCRATCH) begin
			return csr_model[addr[3:0]];
		end else if (addr == `CSR_INSTRET) begin
			return instret_count;
		end
		return '0; // Identity and unknown addresses.
	endfunction

	// Applies one accepted request in order and sets the expected writeback.
	task automatic accept_request(input csr_req_t r);
		word_t   mask;
		word_t   old_val;
		csr_op_t op;
		mask    = r.funct3[2] ? {27'b0, r.zimm} : r.rs1_data;
		op      = r.funct3[1:0];
		old_val = model_read(r.csr_addr);
		exp_wb.valid    = r.valid;
		exp_wb.warp_num = r.warp_num;
		exp_wb.rd       = r.rd;
		exp_wb.wb       = r.wb;
		for (int t = 0; t < `NUM_THREADS; t++) begin
			if (r.csr_addr == `CSR_THREAD_ID) begin
				exp_wb.result[t] = t;
			end else if (r.csr_addr == `CSR_WARP_ID) begin
				exp_wb.result[t] = 32'(r.warp_num);
			end else if (r.csr_addr == `CSR_GWARP_ID) begin
				exp_wb.result[t] = 32'(r.warp_num) + `CORE_ID * `NUM_WARPS;
			end else begin
				exp_wb.result[t] = old_val;
			end
		end
		if (r.csr_addr < `CSR_NUM_SCRATCH && (op == `CSR_OP_RW || mask != '0)) begin
			case (op)
				`CSR_OP_RS: csr_model[r.csr_addr[3:0]] = old_val | mask;
				`CSR_OP_RC: csr_model[r.csr_addr[3:0]] = old_val & ~mask;
				default:    csr_model[r.csr_addr[3:0]] = mask;
			endcase
		end
		accepted_count++;
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CSR_NUM_SCRATCH; i++) begin
				csr_model[i] = '0;
			end
			instret_count  = '0;
			exp_wb         = '0;
			accepted_count = 0;
		end else begin
			if (!no_slot_csr) begin
				if (|req.valid) begin
					accept_request(req);
				end else begin
					exp_wb.valid = '0;
				end
			end
			if (wb_valid) begin
				instret_count++; // Seen by requests from the next edge on.
			end
		end
	end

	task automatic check_outputs();
		check_value("stall_gpr_csr", 32'(stall_gpr_csr), 32'((|req.valid) && no_slot_csr));
		check_value("csr_wb.valid", 32'(csr_wb.valid), 32'(exp_wb.valid));
		if (|exp_wb.valid) begin
			check_value("csr_wb.warp_num", 32'(csr_wb.warp_num), 32'(exp_wb.warp_num));
			check_value("csr_wb.rd", 32'(csr_wb.rd), 32'(exp_wb.rd));
			check_value("csr_wb.wb", 32'(csr_wb.wb), 32'(exp_wb.wb));
			for (int t = 0; t < `NUM_THREADS; t++) begin
				check_value($sformatf("csr_wb.result[%0d]", t), csr_wb.result[t],
					exp_wb.result[t]);
			end
		end
	endtask

	task automatic draw_request(output csr_req_t r);
		int unsigned kind;
		int unsigned f;
		r          = '0;
		r.valid    = thread_mask_t'($urandom % 15 + 1);
		r.warp_num = warp_num_t'($urandom);
		r.rd       = reg_num_t'($urandom);
		r.wb       = 1'($urandom);
		f          = $urandom % 6;
		r.funct3   = (f < 3) ? 3'(f + 1) : 3'(f + 2); // Skips 0 and 4.
		r.rs1_data = ($urandom % 8 == 0) ? '0 : word_t'($urandom);
		r.zimm     = 5'($urandom);
		kind       = $urandom % 16;
		if (kind < 4) begin
			r.csr_addr = prev_addr; // Back to back on one address.
		end else if (kind < 11) begin
			r.csr_addr = csr_addr_t'($urandom % `CSR_NUM_SCRATCH);
		end else if (kind == 11) begin
			r.csr_addr = `CSR_THREAD_ID;
		end else if (kind == 12) begin
			r.csr_addr = `CSR_WARP_ID;
		end else if (kind == 13) begin
			r.csr_addr = `CSR_GWARP_ID;
		end else if (kind == 14) begin
			r.csr_addr = `CSR_INSTRET;
		end else begin
			r.csr_addr = 12'h100 | csr_addr_t'($urandom % 256);
		end
		prev_addr = r.csr_addr;
	endtask

	initial begin
		csr_req_t next_req;
		logic     held;
		seed_dummy   = $urandom(32'hebff);
		rst_n        = 1'b0;
		req          = '0;
		no_slot_csr  = 1'b0;
		wb_valid     = 1'b0;
		prev_addr    = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_outputs();
		// Every scratch CSR and instret reads zero after reset.
		for (int a = 0; a <= `CSR_NUM_SCRATCH; a++) begin
			next_req          = '0;
			next_req.valid    = '1;
			next_req.funct3   = 3'd2;
			next_req.csr_addr = (a == `CSR_NUM_SCRATCH) ? `CSR_INSTRET : csr_addr_t'(a);
			req               = next_req;
			@(negedge clk);
			check_outputs();
			check_value("csr_wb.result[0]", csr_wb.result[0], '0);
		end
		while (accepted_count < NUM_REQS) begin
			held = (|req.valid) && no_slot_csr; // Stalled request stays on the bus.
			if (!held) begin
				if ($urandom % 4 != 0) begin
					draw_request(next_req);
				end else begin
					next_req = '0;
				end
				req = next_req;
			end
			no_slot_csr = ($urandom % 4 == 0);
			wb_valid    = 1'($urandom);
			@(negedge clk);
			check_outputs();
		end
		req         = '0;
		no_slot_csr = 1'b0;
		wb_valid    = 1'b0;
		repeat (2) begin
			@(negedge clk);
			check_outputs();
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns with %0d of %0d requests accepted",
			TIMEOUT_NS, accepted_count, NUM_REQS);
		$display("TESTBENCH FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule
